//--- Makefile
SRCS := $(wildcard hw/*.sv) $(wildcard verif/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vunit_mux_tb: files.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module unit_mux_tb -Mdir obj_dir -f files.f

run: obj_dir/Vunit_mux_tb
	./obj_dir/Vunit_mux_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q '\*\*\* TEST PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

//--- files.f
hw/unit_mux_pkg.sv
hw/unit_dispatch.sv
hw/unit_order_queue.sv
hw/unit_result_select.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/unit_mux_top.sv
verif/unit_mux_tb.sv

//--- hw/alu_unit.sv
// One output register, results appear one cycle after acceptance
// Accepts again while the held result drains in the same cycle

module alu_unit (
    input  logic                  clk_i,
    input  logic                  arst_n_i,

    input  logic                  valid_i,
    output logic                  ready_o,
    input  unit_mux_pkg::instr_t  instr_i,

    output logic                  valid_o,
    input  logic                  ready_i,
    output unit_mux_pkg::result_t result_o
);

    import unit_mux_pkg::*;

    logic              valid_q;
    result_t           result_q;
    logic [DATA_W-1:0] alu_data;

    always_comb begin
        case (instr_i.opcode)
            OP_ADD:  alu_data = instr_i.op_a + instr_i.op_b;
            OP_SUB:  alu_data = instr_i.op_a - instr_i.op_b;
            OP_XOR:  alu_data = instr_i.op_a ^ instr_i.op_b;
            default: alu_data = '0;
        endcase
    end

    assign ready_o = ~valid_q | ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            result_q.id   <= instr_i.id;
            result_q.data <= alu_data;
        end
    end

    assign valid_o  = valid_q;
    assign result_o = result_q;

endmodule

//--- hw/mul_unit.sv
// Shift-add multiplier, one operand bit per cycle, DATA_W cycles per multiply
// Holds a single instruction, keeps only the low DATA_W product bits

module mul_unit (
    input  logic                  clk_i,
    input  logic                  arst_n_i,

    input  logic                  valid_i,
    output logic                  ready_o,
    input  unit_mux_pkg::instr_t  instr_i,

    output logic                  valid_o,
    input  logic                  ready_i,
    output unit_mux_pkg::result_t result_o
);

    import unit_mux_pkg::*;

    localparam int unsigned CNT_W = $clog2(DATA_W);

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_BUSY,
        MUL_DONE
    } mul_state_e;

    mul_state_e        state_q;
    logic [CNT_W-1:0]  bit_cnt_q;
    logic [ID_W-1:0]   id_q;
    logic [DATA_W-1:0] mcand_q;
    logic [DATA_W-1:0] mplier_q;
    logic [DATA_W-1:0] product_q;
    logic              accept;

    assign ready_o = (state_q == MUL_IDLE);
    assign accept  = valid_i & ready_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= MUL_IDLE;
            bit_cnt_q <= '0;
        end else begin
            case (state_q)
                MUL_IDLE: begin
                    if (valid_i) begin
                        state_q   <= MUL_BUSY;
                        bit_cnt_q <= '0;
                    end
                end
                MUL_BUSY: begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                    if (bit_cnt_q == CNT_W'(DATA_W - 1)) begin
                        state_q <= MUL_DONE;
                    end
                end
                MUL_DONE: begin
                    if (ready_i) begin
                        state_q <= MUL_IDLE;
                    end
                end
                default: state_q <= MUL_IDLE;
            endcase
        end
    end

    // Multiplicand walks left, multiplier walks right
    always_ff @(posedge clk_i) begin
        if (accept) begin
            id_q      <= instr_i.id;
            mcand_q   <= instr_i.op_a;
            mplier_q  <= instr_i.op_b;
            product_q <= '0;
        end else if (state_q == MUL_BUSY) begin
            if (mplier_q[0]) begin
                product_q <= product_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign valid_o       = (state_q == MUL_DONE);
    assign result_o.id   = id_q;
    assign result_o.data = product_q;

endmodule

//--- hw/unit_dispatch.sv
// Purely combinational, in_ready_o depends on the opcode of in_instr_i
// The driver must hold the instruction stable while in_valid_i is high

module unit_dispatch (
    input  logic                                 in_valid_i,
    output logic                                 in_ready_o,
    input  unit_mux_pkg::instr_t                 in_instr_i,

    output logic [unit_mux_pkg::UNIT_CNT-1:0]    unit_valid_o,
    input  logic [unit_mux_pkg::UNIT_CNT-1:0]    unit_ready_i,

    output logic                                 enq_valid_o,
    input  logic                                 enq_ready_i,
    output unit_mux_pkg::unit_e                  enq_unit_o
);

    import unit_mux_pkg::*;

    unit_e target_unit;

    // Only multiplies go to the multiplier
    always_comb begin
        case (in_instr_i.opcode)
            OP_MUL:  target_unit = UNIT_MUL;
            default: target_unit = UNIT_ALU;
        endcase
    end

    // Unit and queue both have to take the instruction in the same cycle
    always_comb begin
        unit_valid_o              = '0;
        unit_valid_o[target_unit] = in_valid_i & enq_ready_i;
    end

    assign enq_valid_o = in_valid_i & unit_ready_i[target_unit];
    assign enq_unit_o  = target_unit;
    assign in_ready_o  = enq_ready_i & unit_ready_i[target_unit];

endmodule

//--- hw/unit_mux_pkg.sv
// Shared widths and types for the in-order unit multiplexer
// UNIT_CNT follows the width of unit_e, so a new unit needs a wider enum

package unit_mux_pkg;

    localparam int unsigned DATA_W = 16;
    localparam int unsigned ID_W   = 4;

    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_XOR,
        OP_MUL
    } op_e;

    typedef enum logic [0:0] {
        UNIT_ALU,
        UNIT_MUL
    } unit_e;

    // One slot per encodable unit number
    localparam int unsigned UNIT_CNT = 2 ** $bits(unit_e);

    typedef struct packed {
        logic [ID_W-1:0]   id;
        op_e               opcode;
        logic [DATA_W-1:0] op_a;
        logic [DATA_W-1:0] op_b;
    } instr_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
    } result_t;

endpackage

//--- hw/unit_mux_top.sv
// Results leave in acceptance order whatever the unit latency
// QUEUE_DEPTH bounds the instructions in flight, minimum 2

module unit_mux_top #(
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  logic                  clk_i,
    input  logic                  arst_n_i,

    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  unit_mux_pkg::instr_t  in_instr_i,

    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output unit_mux_pkg::result_t out_result_o
);

    import unit_mux_pkg::*;

    logic    [UNIT_CNT-1:0] unit_in_valid;
    logic    [UNIT_CNT-1:0] unit_in_ready;
    logic    [UNIT_CNT-1:0] unit_out_valid;
    logic    [UNIT_CNT-1:0] unit_out_ready;
    result_t [UNIT_CNT-1:0] unit_out_result;
    logic                   enq_valid;
    logic                   enq_ready;
    unit_e                  enq_unit;
    logic                   deq_valid;
    logic                   deq_ready;
    unit_e                  deq_unit;

    unit_dispatch u_dispatch (
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .in_instr_i   (in_instr_i),
        .unit_valid_o (unit_in_valid),
        .unit_ready_i (unit_in_ready),
        .enq_valid_o  (enq_valid),
        .enq_ready_i  (enq_ready),
        .enq_unit_o   (enq_unit)
    );

    unit_order_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_order_queue (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .enq_valid_i (enq_valid),
        .enq_ready_o (enq_ready),
        .enq_unit_i  (enq_unit),
        .deq_ready_i (deq_ready),
        .deq_valid_o (deq_valid),
        .deq_unit_o  (deq_unit)
    );

    alu_unit u_alu (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (unit_in_valid[UNIT_ALU]),
        .ready_o  (unit_in_ready[UNIT_ALU]),
        .instr_i  (in_instr_i),
        .valid_o  (unit_out_valid[UNIT_ALU]),
        .ready_i  (unit_out_ready[UNIT_ALU]),
        .result_o (unit_out_result[UNIT_ALU])
    );

    mul_unit u_mul (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (unit_in_valid[UNIT_MUL]),
        .ready_o  (unit_in_ready[UNIT_MUL]),
        .instr_i  (in_instr_i),
        .valid_o  (unit_out_valid[UNIT_MUL]),
        .ready_i  (unit_out_ready[UNIT_MUL]),
        .result_o (unit_out_result[UNIT_MUL])
    );

    unit_result_select u_result_select (
        .deq_valid_i   (deq_valid),
        .deq_unit_i    (deq_unit),
        .deq_ready_o   (deq_ready),
        .unit_valid_i  (unit_out_valid),
        .unit_ready_o  (unit_out_ready),
        .unit_result_i (unit_out_result),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .out_result_o  (out_result_o)
    );

endmodule

//--- hw/unit_order_queue.sv
// Circular buffer of unit numbers, QUEUE_DEPTH must be 2 or more
// No enqueue while full, even when the head is popped in the same cycle

module unit_order_queue #(
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  logic                clk_i,
    input  logic                arst_n_i,

    input  logic                enq_valid_i,
    output logic                enq_ready_o,
    input  unit_mux_pkg::unit_e enq_unit_i,

    input  logic                deq_ready_i,
    output logic                deq_valid_o,
    output unit_mux_pkg::unit_e deq_unit_o
);

    import unit_mux_pkg::*;

    localparam int unsigned PTR_W = $clog2(QUEUE_DEPTH);
    localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH + 1);

    unit_e            mem_q [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             enq_fire;
    logic             deq_fire;

    assign enq_ready_o = (count_q != CNT_W'(QUEUE_DEPTH));
    assign deq_valid_o = (count_q != '0);
    assign deq_unit_o  = mem_q[rd_ptr_q];

    assign enq_fire = enq_valid_i & enq_ready_o;
    assign deq_fire = deq_ready_i & deq_valid_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (enq_fire) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (deq_fire) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (enq_fire && !deq_fire) begin
                count_q <= count_q + 1'b1;
            end else if (!enq_fire && deq_fire) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (enq_fire) begin
            mem_q[wr_ptr_q] <= enq_unit_i;
        end
    end

endmodule

//--- hw/unit_result_select.sv
// Only the unit named at the queue head may drive the output
// Output fields read zero whenever out_valid_o is low

module unit_result_select (
    input  logic                                       deq_valid_i,
    input  unit_mux_pkg::unit_e                        deq_unit_i,
    output logic                                       deq_ready_o,

    input  logic [unit_mux_pkg::UNIT_CNT-1:0]          unit_valid_i,
    output logic [unit_mux_pkg::UNIT_CNT-1:0]          unit_ready_o,
    input  unit_mux_pkg::result_t [unit_mux_pkg::UNIT_CNT-1:0] unit_result_i,

    output logic                                       out_valid_o,
    input  logic                                       out_ready_i,
    output unit_mux_pkg::result_t                      out_result_o
);

    import unit_mux_pkg::*;

    always_comb begin
        unit_ready_o = '0;
        out_valid_o  = 1'b0;
        out_result_o = '0;
        if (deq_valid_i) begin
            // Other units keep their results until their turn
            unit_ready_o[deq_unit_i] = out_ready_i;
            out_valid_o              = unit_valid_i[deq_unit_i];
            if (unit_valid_i[deq_unit_i]) begin
                out_result_o = unit_result_i[deq_unit_i];
            end
        end
    end

    // Head entry retires with the output transfer
    assign deq_ready_o = out_valid_o & out_ready_i;

endmodule

//--- verif/unit_mux_tb.sv
// Random stimulus with a fixed seed
// Results are checked in acceptance order and a watchdog ends a stuck run

module unit_mux_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import unit_mux_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int QUEUE_DEPTH   = 4;
    localparam int ORDER_STREAMS = 4;
    localparam int ORDER_ALU     = 5;
    localparam int FULL_COUNT    = 12;
    localparam int TOTAL_INSTR   = 100 + 50 + ORDER_STREAMS * (1 + ORDER_ALU) + 300 + FULL_COUNT;

    logic    clk_i;
    logic    arst_n_i;
    logic    in_valid_i;
    logic    in_ready_o;
    instr_t  in_instr_i;
    logic    out_valid_o;
    logic    out_ready_i;
    result_t out_result_o;

    result_t         scoreboard [$];
    string           test_name;
    // 0 ready high, 1 random, 2 held low
    int              ready_mode;
    int              errors;
    int              checks;
    int              tests_run;
    int              errors_at_start;
    logic [ID_W-1:0] next_id;
    logic            held_valid;
    result_t         held_result;

    unit_mux_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) UUT (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .in_instr_i   (in_instr_i),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_result_o (out_result_o)
    );

    function automatic logic [DATA_W-1:0] ref_result(input op_e op,
                                                     input logic [DATA_W-1:0] a,
                                                     input logic [DATA_W-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_XOR:  return a ^ b;
            default: return a * b;
        endcase
    endfunction

    function automatic instr_t make_instr(input op_e op);
        instr_t ins;
        ins.id     = next_id;
        ins.opcode = op;
        ins.op_a   = DATA_W'($urandom);
        ins.op_b   = DATA_W'($urandom);
        next_id    = next_id + 1'b1;
        return ins;
    endfunction

    function automatic op_e random_alu_op();
        return op_e'(2'($urandom_range(0, 2)));
    endfunction

    function automatic op_e random_op();
        return op_e'(2'($urandom_range(0, 3)));
    endfunction

    // Entered and left 10 ns after a rising edge
    task automatic issue(input instr_t ins);
        in_instr_i = ins;
        in_valid_i = 1'b1;
        @(negedge clk_i);
        while (!in_ready_o) @(negedge clk_i);
        @(posedge clk_i);
        #10;
        in_valid_i = 1'b0;
    endtask

    task automatic start_test(input string name, input int mode);
        @(negedge clk_i);
        test_name       = name;
        errors_at_start = errors;
        ready_mode      = mode;
        @(posedge clk_i);
        #10;
    endtask

    task automatic finish_test();
        while (scoreboard.size() != 0) @(posedge clk_i);
        repeat (2) @(negedge clk_i);
        checks++;
        assert (!out_valid_o) else begin
            $display("test %s: extra result at the output after the last expected one",
                     test_name);
            errors++;
        end
        tests_run++;
        $display("test %s: %s with %0d errors", test_name,
                 (errors == errors_at_start) ? "passed" : "failed", errors - errors_at_start);
    endtask

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        out_ready_i = 1'b0;
        forever begin
            @(posedge clk_i);
            #10;
            case (ready_mode)
                1:       out_ready_i = ($urandom_range(0, 1) == 0);
                2:       out_ready_i = 1'b0;
                default: out_ready_i = 1'b1;
            endcase
        end
    end

    // Transfers are predicted at the falling edge where both sides are stable
    always @(negedge clk_i) begin
        result_t expected;
        result_t entry;
        if (arst_n_i) begin
            if (held_valid) begin
                checks++;
                assert (out_valid_o && out_result_o == held_result) else begin
                    $display("test %s: output changed while waiting for ready", test_name);
                    errors++;
                end
            end
            if (!out_valid_o) begin
                checks++;
                assert (out_result_o == '0) else begin
                    $display("test %s: output fields not zero while out_valid_o is low",
                             test_name);
                    errors++;
                end
            end
            if (out_valid_o && out_ready_i) begin
                assert (scoreboard.size() != 0) else begin
                    $display("test %s: output transfer with no instruction outstanding",
                             test_name);
                    errors++;
                end
                if (scoreboard.size() != 0) begin
                    expected = scoreboard.pop_front();
                    checks++;
                    assert (out_result_o == expected) else begin
                        $display({"mismatch in test %s: expected id %h data %h, ",
                                  "actual id %h data %h"},
                                 test_name, expected.id, expected.data,
                                 out_result_o.id, out_result_o.data);
                        errors++;
                    end
                end
            end
            if (in_valid_i && in_ready_o) begin
                entry.id   = in_instr_i.id;
                entry.data = ref_result(in_instr_i.opcode, in_instr_i.op_a, in_instr_i.op_b);
                scoreboard.push_back(entry);
            end
            assert (scoreboard.size() <= QUEUE_DEPTH) else begin
                $display("test %s: more instructions in flight than the queue depth", test_name);
                errors++;
            end
            held_valid  = out_valid_o && !out_ready_i;
            held_result = out_result_o;
        end
    end

    initial begin
        #(TOTAL_INSTR * (DATA_W + 4) * CLK_PERIOD * 4);
        $display("watchdog: run did not finish in time, a result is missing or the DUT is stuck");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(32'h1c5462e3));
        arst_n_i        = 1'b0;
        in_valid_i      = 1'b0;
        in_instr_i      = '0;
        ready_mode      = 0;
        next_id         = '0;
        errors          = 0;
        checks          = 0;
        tests_run       = 0;
        errors_at_start = 0;
        held_valid      = 1'b0;
        held_result     = '0;
        test_name       = "reset";
        repeat (16) @(posedge clk_i);
        #10;
        arst_n_i = 1'b1;

        start_test("reset", 0);
        @(negedge clk_i);
        checks++;
        assert (!out_valid_o && in_ready_o) else begin
            $display("test reset: out_valid_o or in_ready_o has the wrong level after reset");
            errors++;
        end
        finish_test();

        start_test("alu", 0);
        repeat (100) issue(make_instr(random_alu_op()));
        finish_test();

        start_test("multiply", 0);
        repeat (50) issue(make_instr(OP_MUL));
        finish_test();

        // A slow multiply ahead of fast ALU work
        start_test("ordering", 0);
        for (int s = 0; s < ORDER_STREAMS; s++) begin
            issue(make_instr(OP_MUL));
            repeat (ORDER_ALU) issue(make_instr(random_alu_op()));
        end
        finish_test();

        start_test("backpressure", 1);
        repeat (300) issue(make_instr(random_op()));
        finish_test();

        start_test("full_queue", 2);
        fork
            begin
                for (int i = 0; i < FULL_COUNT; i++) begin
                    issue(make_instr(random_op()));
                end
            end
            begin
                repeat (4 * DATA_W) @(negedge clk_i);
                checks++;
                assert (!in_ready_o) else begin
                    $display("test full_queue: in_ready_o still high with the output stalled");
                    errors++;
                end
                ready_mode = 0;
            end
        join
        finish_test();

        $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
